// File: hw/mul_pkg.sv
`default_nettype none

package mul_pkg;

    localparam int XLEN        = 64;
    localparam int PROD_W      = 128;
    localparam int PP_NUM      = 33;   // radix-4 rows over a 66-bit signed multiplier
    localparam int PP_W        = 130;
    localparam int TAG_W       = 4;
    localparam int FIFO_DEPTH  = 4;    // also the upstream credits after reset
    localparam int RES_CREDITS = 2;

    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    localparam int ISSUE_CW   = $clog2(RES_CREDITS + 1);
    localparam int CSA_LEVELS = 8;     // 33 22 15 10 7 5 4 3 2

    typedef enum logic [1:0] {
        MUL_LO = 2'd0,
        MUL_HI = 2'd1,
        MUL_W  = 2'd2
    } mul_op_e;

    typedef struct packed {
        mul_op_e            op;
        logic               a_signed;
        logic               b_signed;
        logic [XLEN-1:0]    a;
        logic [XLEN-1:0]    b;
        logic [TAG_W-1:0]   tag;
    } mul_req_t;

    typedef struct packed {
        logic [XLEN-1:0]    data;
        logic [TAG_W-1:0]   tag;
    } mul_res_t;

    typedef logic [PP_NUM-1:0][PP_W-1:0] pp_array_t;

    // rows left after a given number of 3:2 levels
    function automatic int csa_rows(input int level);
        int n;
        n = PP_NUM;
        for (int l = 0; l < level; l++) begin
            n = 2 * (n / 3) + n % 3;
        end
        return n;
    endfunction

endpackage

`default_nettype wire

// File: hw/booth_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module booth_encoder
    import mul_pkg::*;
(
    input  mul_req_t  req_i,
    output pp_array_t pp_o
);

    logic [XLEN:0]          ext_a;
    logic [XLEN:0]          ext_b;
    logic [XLEN+2:0]        a_pad;  // bit 0 is a[-1]
    logic signed [PP_W-1:0] b_wide;

    // 65-bit operands, sign bit only when signed
    assign ext_a = {req_i.a_signed & req_i.a[XLEN-1], req_i.a};
    assign ext_b = {req_i.b_signed & req_i.b[XLEN-1], req_i.b};

    // one more copy of the sign so the top triplet sees it
    assign a_pad = {ext_a[XLEN], ext_a, 1'b0};

    assign b_wide = PP_W'(signed'(ext_b));

    for (genvar i = 0; i < PP_NUM; i++) begin : g_row
        logic [2:0]             trip;
        logic signed [PP_W-1:0] mult;

        assign trip = a_pad[2*i+2 -: 3];

        always_comb begin
            case (trip)
                3'b001,
                3'b010:  mult = b_wide;           // +b
                3'b011:  mult = b_wide <<< 1;     // +2b
                3'b100:  mult = -(b_wide <<< 1);  // -2b
                3'b101,
                3'b110:  mult = -b_wide;          // -b
                default: mult = '0;               // 000 and 111
            endcase
        end

        // weight 4^i, stays sign-extended up to PP_W
        assign pp_o[i] = mult << (2 * i);
    end

endmodule

`default_nettype wire

// File: hw/csa_tree.sv
`timescale 1ns/1ps
`default_nettype none

module csa_tree
    import mul_pkg::*;
(
    input  pp_array_t         pp_i,
    output logic [PROD_W-1:0] sum_o,
    output logic [PROD_W-1:0] carry_o
);

    // rows[l] holds the csa_rows(l) rows entering level l
    wire [PROD_W-1:0] rows [0:CSA_LEVELS][0:PP_NUM-1];

    for (genvar r = 0; r < PP_NUM; r++) begin : g_in
        assign rows[0][r] = pp_i[r][PROD_W-1:0];  // bits above 128 never reach the product
    end

    for (genvar l = 0; l < CSA_LEVELS; l++) begin : g_level
        // groups of three rows go through a row of full adders
        for (genvar g = 0; g < csa_rows(l) / 3; g++) begin : g_csa
            wire [PROD_W-1:0] x;
            wire [PROD_W-1:0] y;
            wire [PROD_W-1:0] z;
            wire [PROD_W-1:0] maj;

            assign x   = rows[l][3*g];
            assign y   = rows[l][3*g+1];
            assign z   = rows[l][3*g+2];
            assign maj = (x & y) | (x & z) | (y & z);

            assign rows[l+1][2*g]   = x ^ y ^ z;
            assign rows[l+1][2*g+1] = {maj[PROD_W-2:0], 1'b0};  // carry moves up one bit
        end

        // leftover rows skip this level
        for (genvar r = 0; r < csa_rows(l) % 3; r++) begin : g_pass
            assign rows[l+1][2*(csa_rows(l)/3) + r] = rows[l][3*(csa_rows(l)/3) + r];
        end
    end

    assign sum_o   = rows[CSA_LEVELS][0];
    assign carry_o = rows[CSA_LEVELS][1];

endmodule

`default_nettype wire

// File: hw/mul_core.sv
`timescale 1ns/1ps
`default_nettype none

module mul_core
    import mul_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     req_valid_i,
    input  mul_req_t req_i,
    output logic     done_o,
    output mul_res_t res_o
);

    pp_array_t         pp;
    logic [PROD_W-1:0] tree_sum;
    logic [PROD_W-1:0] tree_carry;

    logic              s1_valid;
    logic [PROD_W-1:0] s1_sum;
    logic [PROD_W-1:0] s1_carry;
    mul_op_e           s1_op;
    logic [TAG_W-1:0]  s1_tag;

    logic [PROD_W-1:0] product;
    logic [XLEN-1:0]   word;

    booth_encoder u_booth (
        .req_i (req_i),
        .pp_o  (pp)
    );

    csa_tree u_tree (
        .pp_i    (pp),
        .sum_o   (tree_sum),
        .carry_o (tree_carry)
    );

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid <= 1'b0;
            done_o   <= 1'b0;
        end else begin
            s1_valid <= req_valid_i;
            done_o   <= s1_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            s1_sum   <= tree_sum;
            s1_carry <= tree_carry;
            s1_op    <= req_i.op;
            s1_tag   <= req_i.tag;
        end
        if (s1_valid) begin
            res_o.data <= word;
            res_o.tag  <= s1_tag;
        end
    end

    assign product = s1_sum + s1_carry;  // final carry-propagate add

    always_comb begin
        case (s1_op)
            MUL_HI:  word = product[PROD_W-1:XLEN];
            MUL_W:   word = {{(XLEN/2){product[XLEN/2-1]}}, product[XLEN/2-1:0]};
            default: word = product[XLEN-1:0];
        endcase
    end

endmodule

`default_nettype wire

// File: hw/result_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module result_fifo
    import mul_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     push_i,
    input  mul_res_t push_data_i,
    input  logic     pop_i,
    output mul_res_t head_o,
    output logic     not_empty_o
);

    mul_res_t           mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
            if (pop_i)  rd_ptr <= rd_ptr + 1'b1;
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    assign head_o      = mem[rd_ptr];
    assign not_empty_o = (count != '0);

endmodule

`default_nettype wire

// File: hw/result_issue.sv
`timescale 1ns/1ps
`default_nettype none

module result_issue
    import mul_pkg::*;
(
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic not_empty_i,
    input  logic res_credit_i,
    output logic pop_o,
    output logic res_valid_o,
    output logic req_credit_o
);

    logic [ISSUE_CW-1:0] credits;  // toward the consumer
    logic                issue;

    assign issue = not_empty_i && (credits != '0);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credits     <= ISSUE_CW'(RES_CREDITS);
            res_valid_o <= 1'b0;
        end else begin
            case ({issue, res_credit_i})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;  // none, or spend and refill together
            endcase
            res_valid_o <= issue;
        end
    end

    assign pop_o        = issue;
    assign req_credit_o = res_valid_o;  // a queue entry frees up with each issue

endmodule

`default_nettype wire

// File: hw/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit
    import mul_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     req_valid_i,
    input  mul_req_t req_i,
    output logic     req_credit_o,
    output logic     res_valid_o,
    output mul_res_t res_o,
    input  logic     res_credit_i
);

    logic     core_done;
    mul_res_t core_res;
    logic     fifo_pop;
    logic     fifo_not_empty;
    mul_res_t fifo_head;

    mul_core u_core (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .done_o      (core_done),
        .res_o       (core_res)
    );

    result_fifo u_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (core_done),
        .push_data_i (core_res),
        .pop_i       (fifo_pop),
        .head_o      (fifo_head),
        .not_empty_o (fifo_not_empty)
    );

    result_issue u_issue (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .not_empty_i  (fifo_not_empty),
        .res_credit_i (res_credit_i),
        .pop_o        (fifo_pop),
        .res_valid_o  (res_valid_o),
        .req_credit_o (req_credit_o)
    );

    // output word lines up with res_valid_o
    always_ff @(posedge clk_i) begin
        if (fifo_pop) begin
            res_o <= fifo_head;
        end
    end

endmodule

`default_nettype wire

// File: verification/mul_unit_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit_checker
    import mul_pkg::*;
(
    input logic             clk_i,
    input logic             rst_n_i,
    input logic             push_i,
    input logic             pop_i,
    input logic [FIFO_AW:0] fifo_count_i,
    input logic             res_credit_i,
    input logic             res_valid_i
);

    int consumer_credits;  // grants seen at the pins minus issues

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            consumer_credits <= RES_CREDITS;
        end else begin
            consumer_credits <= consumer_credits - int'(pop_i) + int'(res_credit_i);
        end
    end

    // a full queue takes a push only while its head leaves
    no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (push_i && fifo_count_i == (FIFO_AW+1)'(FIFO_DEPTH)) |-> pop_i)
        else $error("push into a full result queue");

    no_issue_without_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop_i |-> consumer_credits > 0)
        else $error("result issued with no consumer credit");

    valid_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(res_valid_i))
        else $error("res_valid_o is unknown");

endmodule

`default_nettype wire

// File: verification/tb_mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mul_unit
    import mul_pkg::*;
();

    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DELAY    = 2;
    localparam int RESET_CYCLES   = 16;
    localparam int TOTAL_REQ      = 3 * 80 + 64 + 2 * 100;
    localparam int TIMEOUT_CYCLES = TOTAL_REQ * 40 + 2000;
    localparam int DRAIN_LIMIT    = 400;

    logic     clk;
    logic     rst_n;
    logic     req_valid;
    mul_req_t req;
    logic     req_credit;
    logic     res_valid;
    mul_res_t res;
    logic     res_credit;

    logic [63:0] rng_state = 64'd87933;
    mul_res_t    exp_q[$];
    int          up_credits = FIFO_DEPTH;
    int          dn_credits = RES_CREDITS;
    int          owed;       // results received, credit not yet given back
    int          tag_count;
    int          results;
    int          returned;
    int          errors;
    int          tests_run;

    mul_unit dut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .req_valid_i  (req_valid),
        .req_i        (req),
        .req_credit_o (req_credit),
        .res_valid_o  (res_valid),
        .res_o        (res),
        .res_credit_i (res_credit)
    );

    bind mul_unit mul_unit_checker u_checker (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .push_i       (u_fifo.push_i),
        .pop_i        (u_fifo.pop_i),
        .fifo_count_i (u_fifo.count),
        .res_credit_i (res_credit_i),
        .res_valid_i  (u_issue.res_valid_o)
    );

    function automatic logic [63:0] xorshift();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 7;
        rng_state ^= rng_state << 17;
        return rng_state;
    endfunction

    // full 128-bit product of the extended operands, word picked by op
    function automatic mul_res_t reference_result(input mul_req_t r);
        logic [PROD_W-1:0] ea;
        logic [PROD_W-1:0] eb;
        logic [PROD_W-1:0] p;
        int                lo_word;
        mul_res_t          e;
        ea = r.a_signed ? {{XLEN{r.a[XLEN-1]}}, r.a} : {{XLEN{1'b0}}, r.a};
        eb = r.b_signed ? {{XLEN{r.b[XLEN-1]}}, r.b} : {{XLEN{1'b0}}, r.b};
        p  = ea * eb;  // modulo 2^128, exact for two's complement
        lo_word = p[XLEN/2-1:0];
        case (r.op)
            MUL_HI:  e.data = p[PROD_W-1:XLEN];
            MUL_W:   e.data = XLEN'(lo_word);  // signed 32-bit word widened
            default: e.data = p[XLEN-1:0];
        endcase
        e.tag = r.tag;
        return e;
    endfunction

    function automatic logic [XLEN-1:0] corner_value(input int i);
        case (i % 4)
            0:       return '0;
            1:       return '1;
            2:       return {1'b1, {(XLEN-1){1'b0}}};
            default: return 64'd1;
        endcase
    endfunction

    function automatic mul_op_e random_op(input logic [63:0] rnd);
        case (rnd[5:0] % 6'd3)
            6'd0:    return MUL_LO;
            6'd1:    return MUL_HI;
            default: return MUL_W;
        endcase
    endfunction

    function automatic mul_req_t make_req(input int id, input int k);
        mul_req_t    r;
        logic [63:0] rnd;
        rnd        = xorshift();
        r.a        = xorshift();
        r.b        = xorshift();
        r.op       = random_op(rnd);
        r.a_signed = rnd[8];
        r.b_signed = rnd[9];
        r.tag      = '0;
        case (id)
            1: begin
                r.op       = rnd[6] ? MUL_HI : MUL_LO;
                r.a_signed = 1'b0;
                r.b_signed = 1'b0;
            end
            2: begin
                r.op       = rnd[6] ? MUL_HI : MUL_LO;
                r.a_signed = 1'b1;  // b signed or not
            end
            3: r.op = MUL_W;
            4: begin
                r.a        = corner_value(k);
                r.b        = corner_value(k / 4);
                r.a_signed = k[4];
                r.b_signed = k[5];
            end
            default: ;
        endcase
        return r;
    endfunction

    task automatic check_result(input mul_res_t got, input mul_res_t exp);
        if (got !== exp) begin
            $display("error %0t: result tag %0d data %h, expected tag %0d data %h",
                     $time, got.tag, got.data, exp.tag, exp.data);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("error %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic sample_outputs();
        if ($isunknown(res_valid)) begin
            $display("res_valid_o is unknown at %0t", $time);
            errors++;
        end
        if (req_credit !== res_valid) begin
            $display("error %0t: req_credit_o %b differs from res_valid_o %b",
                     $time, req_credit, res_valid);
            errors++;
        end
        if (req_credit) begin
            up_credits++;
            returned++;
        end
        if (res_valid) begin
            results++;
            owed++;
            if (dn_credits == 0) begin
                $display("a result came out at %0t while the consumer held no credit", $time);
                errors++;
            end else begin
                dn_credits--;
            end
            if (exp_q.size() == 0) begin
                $display("a result came out at %0t with no request outstanding", $time);
                errors++;
            end else begin
                check_result(res, exp_q.pop_front());
            end
        end
    endtask

    // one clock: drive after the edge, look at outputs mid-cycle
    task automatic step(input logic send, input mul_req_t r, input logic grant);
        @(posedge clk);
        #DRIVE_DELAY;
        if (send) begin
            r.tag = TAG_W'(tag_count);
            tag_count++;
            exp_q.push_back(reference_result(r));
            up_credits--;
        end
        if (grant) begin
            owed--;
            dn_credits++;
        end
        req_valid  = send;
        req        = r;
        res_credit = grant;
        @(negedge clk);
        sample_outputs();
    endtask

    task automatic run_test(input int id, input string name, input int n_req);
        int          sent;
        int          hold;
        int          cycles;
        int          err0;
        int          res0;
        int          ret0;
        logic        send;
        logic        grant;
        logic [63:0] rnd;
        sent = 0;
        hold = 0;
        err0 = errors;
        res0 = results;
        ret0 = returned;
        while (sent < n_req) begin
            rnd   = xorshift();
            send  = (up_credits > 0) && (id >= 5 || rnd[0]);
            grant = (owed > 0) && (id == 5 || rnd[1]);
            if (id == 6) begin
                if (hold > 0) begin
                    hold--;
                    grant = 1'b0;
                end else if (rnd[4:2] == 3'd0) begin
                    hold  = 10 + int'(rnd[9:5]);  // long consumer stall
                    grant = 1'b0;
                end else begin
                    grant = owed > 0;
                end
            end
            if (send) begin
                step(1'b1, make_req(id, sent), grant);
                sent++;
            end else begin
                step(1'b0, '0, grant);
            end
        end
        cycles = 0;
        while ((exp_q.size() != 0 || owed > 0) && cycles < DRAIN_LIMIT) begin
            step(1'b0, '0, owed > 0);
            cycles++;
        end
        if (cycles == DRAIN_LIMIT) begin
            $display("test %0d: results still missing after %0d idle cycles", id, cycles);
            errors++;
        end
        check_count("upstream credits", up_credits, FIFO_DEPTH);
        check_count("results", results - res0, n_req);
        check_count("credits returned", returned - ret0, results - res0);
        tests_run++;
        $display("test %0d %s: %0d results, %0d errors", id, name, results - res0,
                 errors - err0);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors found");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        res_credit = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        run_test(1, "unsigned products", 80);
        run_test(2, "signed and mixed products", 80);
        run_test(3, "word results", 80);
        run_test(4, "corner operands", 64);
        run_test(5, "full-rate flow", 100);
        run_test(6, "back-pressure", 100);
        $display("%0d tests, %0d results, %0d errors", tests_run, results, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mul_unit.f
hw/mul_pkg.sv
hw/booth_encoder.sv
hw/csa_tree.sv
hw/mul_core.sv
hw/result_fifo.sv
hw/result_issue.sv
hw/mul_unit.sv
verification/mul_unit_checker.sv
verification/tb_mul_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_mul_unit -f mul_unit.f -Mdir obj_dir
./obj_dir/Vtb_mul_unit | tee "$LOG"

if grep -q "Errors found" "$LOG"; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"
